// File: Makefile
SRCS := $(wildcard hdl/*.sv tests/*.sv include/*.svh)

.PHONY: run clean

run: obj_dir/Vtb_istream
	@out="$$(./obj_dir/Vtb_istream)"; echo "$$out"; echo "$$out" | grep -q "Done: no errors"

obj_dir/Vtb_istream: compile.f $(SRCS)
	verilator --binary --timing --assert -j 0 --top-module tb_istream -f compile.f

clean:
	rm -rf obj_dir

// File: compile.f
+incdir+include
hdl/istream_pkg.sv
hdl/parcel_marker.sv
hdl/set_queue.sv
hdl/way_select.sv
hdl/istream.sv
tests/tb_istream.sv

// File: hdl/istream.sv
`timescale 1ns/1ps

module istream #(
    parameter int ISTREAM_SETS = 8
) (
    input  logic                                              CLK,
    input  logic                                              nRST,

    // enqueue
    input  logic                                              valid_enq,
    input  istream_pkg::parcel_mask_t                         parcel_valid_enq,
    input  istream_pkg::parcel_block_t                        parcels_enq,
    input  istream_pkg::block_pc_t                            block_pc_enq,
    output logic                                              stall_enq,

    // dequeue
    output logic                                              valid_deq,
    output istream_pkg::way_mask_t                            valid_by_way_deq,
    output istream_pkg::instr_t [istream_pkg::DEQ_WAYS-1:0]   instr_by_way_deq,
    output istream_pkg::pc_t [istream_pkg::DEQ_WAYS-1:0]      pc_by_way_deq,
    input  logic                                              stall_deq,

    input  logic                                              restart
);

    // ------------------------------------------------------------
    // stage wiring

    logic                             enq_write;
    istream_pkg::parcel_mask_t        enq_uncompressed;
    istream_pkg::parcel_mask_t        enq_marker;

    istream_pkg::window_mask_t        window_valid;
    istream_pkg::window_mask_t        window_uncompressed;
    istream_pkg::window_mask_t        window_marker;
    istream_pkg::parcel_block_t [1:0] window_parcels;
    istream_pkg::block_pc_t [1:0]     window_pc;
    logic [1:0]                       set_present;

    istream_pkg::window_mask_t        ack_vec;
    logic                             retire_one;
    logic                             retire_two;

    // mark stage
    parcel_marker u_parcel_marker (
        .CLK              (CLK),
        .nRST             (nRST),
        .restart          (restart),
        .valid_enq        (valid_enq),
        .stall_enq        (stall_enq),
        .parcel_valid_enq (parcel_valid_enq),
        .parcels_enq      (parcels_enq),
        .enq_write        (enq_write),
        .enq_uncompressed (enq_uncompressed),
        .enq_marker       (enq_marker)
    );

    // queue stage
    set_queue #(
        .ISTREAM_SETS (ISTREAM_SETS)
    ) u_set_queue (
        .CLK                 (CLK),
        .nRST                (nRST),
        .restart             (restart),
        .enq_write           (enq_write),
        .parcel_valid_enq    (parcel_valid_enq),
        .enq_uncompressed    (enq_uncompressed),
        .enq_marker          (enq_marker),
        .parcels_enq         (parcels_enq),
        .block_pc_enq        (block_pc_enq),
        .stall_deq           (stall_deq),
        .ack_vec             (ack_vec),
        .retire_one          (retire_one),
        .retire_two          (retire_two),
        .stall_enq           (stall_enq),
        .window_valid        (window_valid),
        .window_uncompressed (window_uncompressed),
        .window_marker       (window_marker),
        .window_parcels      (window_parcels),
        .window_pc           (window_pc),
        .set_present         (set_present)
    );

    // select stage
    way_select u_way_select (
        .window_valid        (window_valid),
        .window_uncompressed (window_uncompressed),
        .window_marker       (window_marker),
        .window_parcels      (window_parcels),
        .window_pc           (window_pc),
        .set_present         (set_present),
        .valid_deq           (valid_deq),
        .valid_by_way_deq    (valid_by_way_deq),
        .instr_by_way_deq    (instr_by_way_deq),
        .pc_by_way_deq       (pc_by_way_deq),
        .ack_vec             (ack_vec),
        .retire_one          (retire_one),
        .retire_two          (retire_two)
    );

endmodule

// File: hdl/istream_pkg.sv
package istream_pkg;

    // ------------------------------------------------------------
    // geometry

    // parcels in one fetch block, and in one queue set
    localparam int PARCELS_PER_SET = 8;

    // dequeue window spans the two oldest sets
    localparam int WINDOW_PARCELS = 2 * PARCELS_PER_SET;

    // instructions handed out per cycle at most
    localparam int DEQ_WAYS = 4;

    // ------------------------------------------------------------
    // data types

    // one 16-bit instruction parcel
    typedef logic [15:0] parcel_t;

    // assembled instruction, upper half zero when 16-bit
    typedef logic [31:0] instr_t;

    // byte address
    typedef logic [31:0] pc_t;

    // base PC of a block without its low four bits
    typedef logic [27:0] block_pc_t;

    typedef logic [PARCELS_PER_SET-1:0] parcel_mask_t;
    typedef logic [PARCELS_PER_SET*16-1:0] parcel_block_t;

    typedef logic [WINDOW_PARCELS-1:0] window_mask_t;
    typedef logic [3:0] window_index_t;

    typedef logic [DEQ_WAYS-1:0] way_mask_t;

endpackage

// File: hdl/parcel_marker.sv
`timescale 1ns/1ps

module parcel_marker (
    input  logic                        CLK,
    input  logic                        nRST,
    input  logic                        restart,
    input  logic                        valid_enq,
    input  logic                        stall_enq,
    input  istream_pkg::parcel_mask_t   parcel_valid_enq,
    input  istream_pkg::parcel_block_t  parcels_enq,
    output logic                        enq_write,
    output istream_pkg::parcel_mask_t   enq_uncompressed,
    output istream_pkg::parcel_mask_t   enq_marker
);

    // carry[i] set when the previous valid parcel opened a 32-bit instr
    logic [istream_pkg::PARCELS_PER_SET:0] carry;
    logic                                  carry_q;

    assign enq_write = valid_enq & ~stall_enq;

    always_comb begin
        carry[0] = carry_q;
        for (int i = 0; i < istream_pkg::PARCELS_PER_SET; i++) begin
            enq_uncompressed[i] = (parcels_enq[16*i +: 2] == 2'b11);
            if (!parcel_valid_enq[i]) begin
                // holes pass the state through
                enq_marker[i] = 1'b0;
                carry[i+1]    = carry[i];
            end else if (carry[i]) begin
                // upper half of the pending instr
                enq_marker[i] = 1'b0;
                carry[i+1]    = 1'b0;
            end else begin
                enq_marker[i] = 1'b1;
                carry[i+1]    = enq_uncompressed[i];
            end
        end
    end

    // split instr state across blocks
    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            carry_q <= 1'b0;
        end else if (restart) begin
            carry_q <= 1'b0;
        end else if (enq_write) begin
            carry_q <= carry[istream_pkg::PARCELS_PER_SET];
        end
    end

endmodule

// File: hdl/set_queue.sv
`timescale 1ns/1ps

module set_queue #(
    parameter int ISTREAM_SETS = 8
) (
    input  logic                             CLK,
    input  logic                             nRST,
    input  logic                             restart,
    input  logic                             enq_write,
    input  istream_pkg::parcel_mask_t        parcel_valid_enq,
    input  istream_pkg::parcel_mask_t        enq_uncompressed,
    input  istream_pkg::parcel_mask_t        enq_marker,
    input  istream_pkg::parcel_block_t       parcels_enq,
    input  istream_pkg::block_pc_t           block_pc_enq,
    input  logic                             stall_deq,
    input  istream_pkg::window_mask_t        ack_vec,
    input  logic                             retire_one,
    input  logic                             retire_two,
    output logic                             stall_enq,
    output istream_pkg::window_mask_t        window_valid,
    output istream_pkg::window_mask_t        window_uncompressed,
    output istream_pkg::window_mask_t        window_marker,
    output istream_pkg::parcel_block_t [1:0] window_parcels,
    output istream_pkg::block_pc_t [1:0]     window_pc,
    output logic [1:0]                       set_present
);

    localparam int IDX_W = $clog2(ISTREAM_SETS);
    localparam int PPS   = istream_pkg::PARCELS_PER_SET;

    // payload, addressed by pointer index
    istream_pkg::parcel_block_t parcel_mem [ISTREAM_SETS];
    istream_pkg::block_pc_t     pc_mem [ISTREAM_SETS];

    // masks kept oldest first
    istream_pkg::parcel_mask_t valid_q [ISTREAM_SETS];
    istream_pkg::parcel_mask_t unc_q [ISTREAM_SETS];
    istream_pkg::parcel_mask_t marker_q [ISTREAM_SETS];
    istream_pkg::parcel_mask_t valid_keep [ISTREAM_SETS];
    istream_pkg::parcel_mask_t marker_keep [ISTREAM_SETS];
    istream_pkg::parcel_mask_t valid_n [ISTREAM_SETS];
    istream_pkg::parcel_mask_t unc_n [ISTREAM_SETS];
    istream_pkg::parcel_mask_t marker_n [ISTREAM_SETS];

    // msb of each pointer is the wrap bit
    logic [IDX_W:0]   enq_ptr;
    logic [IDX_W:0]   deq_ptr;
    logic [IDX_W:0]   occupancy;
    logic [IDX_W:0]   enq_slot;
    logic [IDX_W-1:0] deq_idx0;
    logic [IDX_W-1:0] deq_idx1;
    logic [1:0]       retire_cnt;

    // ------------------------------------------------------------
    // pointers and window

    assign occupancy = enq_ptr - deq_ptr;
    assign stall_enq = (enq_ptr[IDX_W-1:0] == deq_ptr[IDX_W-1:0])
                     & (enq_ptr[IDX_W] != deq_ptr[IDX_W]);

    assign retire_cnt = stall_deq ? 2'd0 : {retire_two, retire_one & ~retire_two};
    assign enq_slot   = occupancy - (IDX_W+1)'(retire_cnt);

    assign deq_idx0 = deq_ptr[IDX_W-1:0];
    assign deq_idx1 = deq_idx0 + IDX_W'(1);

    assign set_present[0] = (occupancy != '0);
    assign set_present[1] = (occupancy > (IDX_W+1)'(1));

    assign window_valid        = {valid_q[1], valid_q[0]};
    assign window_uncompressed = {unc_q[1], unc_q[0]};
    assign window_marker       = {marker_q[1], marker_q[0]};
    assign window_parcels      = {parcel_mem[deq_idx1], parcel_mem[deq_idx0]};
    assign window_pc           = {pc_mem[deq_idx1], pc_mem[deq_idx0]};

    // ------------------------------------------------------------
    // next masks: clear acks, shift out retired sets, add new set

    always_comb begin
        for (int s = 0; s < ISTREAM_SETS; s++) begin
            valid_keep[s]  = valid_q[s];
            marker_keep[s] = marker_q[s];
        end
        if (!stall_deq) begin
            valid_keep[0]  = valid_q[0] & ~ack_vec[0 +: PPS];
            valid_keep[1]  = valid_q[1] & ~ack_vec[PPS +: PPS];
            marker_keep[0] = marker_q[0] & ~ack_vec[0 +: PPS];
            marker_keep[1] = marker_q[1] & ~ack_vec[PPS +: PPS];
        end
        for (int s = 0; s < ISTREAM_SETS; s++) begin
            if (s + int'(retire_cnt) < ISTREAM_SETS) begin
                valid_n[s]  = valid_keep[s + int'(retire_cnt)];
                unc_n[s]    = unc_q[s + int'(retire_cnt)];
                marker_n[s] = marker_keep[s + int'(retire_cnt)];
            end else begin
                valid_n[s]  = '0;
                unc_n[s]    = '0;
                marker_n[s] = '0;
            end
            if (enq_write && (int'(enq_slot) == s)) begin
                valid_n[s]  = parcel_valid_enq;
                unc_n[s]    = enq_uncompressed;
                marker_n[s] = enq_marker;
            end
        end
    end

    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            enq_ptr <= '0;
            deq_ptr <= '0;
            for (int s = 0; s < ISTREAM_SETS; s++) begin
                valid_q[s]  <= '0;
                unc_q[s]    <= '0;
                marker_q[s] <= '0;
            end
        end else if (restart) begin
            enq_ptr <= '0;
            deq_ptr <= '0;
            for (int s = 0; s < ISTREAM_SETS; s++) begin
                valid_q[s]  <= '0;
                unc_q[s]    <= '0;
                marker_q[s] <= '0;
            end
        end else begin
            if (enq_write) begin
                enq_ptr <= enq_ptr + (IDX_W+1)'(1);
            end
            deq_ptr <= deq_ptr + (IDX_W+1)'(retire_cnt);
            for (int s = 0; s < ISTREAM_SETS; s++) begin
                valid_q[s]  <= valid_n[s];
                unc_q[s]    <= unc_n[s];
                marker_q[s] <= marker_n[s];
            end
        end
    end

    always_ff @(posedge CLK) begin
        if (enq_write) begin
            parcel_mem[enq_ptr[IDX_W-1:0]] <= parcels_enq;
            pc_mem[enq_ptr[IDX_W-1:0]]     <= block_pc_enq;
        end
    end

    // ------------------------------------------------------------
    // checks

    // marker must honor the full flag from this queue
    a_no_write_when_full: assert property (
        @(posedge CLK) disable iff (!nRST) !(enq_write && stall_enq)
    );

    // set 1 never leaves ahead of set 0
    a_retire_order: assert property (
        @(posedge CLK) disable iff (!nRST) retire_two |-> retire_one
    );

endmodule

// File: hdl/way_select.sv
`timescale 1ns/1ps

module way_select (
    input  istream_pkg::window_mask_t                         window_valid,
    input  istream_pkg::window_mask_t                         window_uncompressed,
    input  istream_pkg::window_mask_t                         window_marker,
    input  istream_pkg::parcel_block_t [1:0]                  window_parcels,
    input  istream_pkg::block_pc_t [1:0]                      window_pc,
    input  logic [1:0]                                        set_present,
    output logic                                              valid_deq,
    output istream_pkg::way_mask_t                            valid_by_way_deq,
    output istream_pkg::instr_t [istream_pkg::DEQ_WAYS-1:0]   instr_by_way_deq,
    output istream_pkg::pc_t [istream_pkg::DEQ_WAYS-1:0]      pc_by_way_deq,
    output istream_pkg::window_mask_t                         ack_vec,
    output logic                                              retire_one,
    output logic                                              retire_two
);

    localparam int PPS = istream_pkg::PARCELS_PER_SET;
    localparam int WP  = istream_pkg::WINDOW_PARCELS;

    istream_pkg::parcel_t parcel_vec [WP];
    logic                 set0_done;
    logic                 set1_done;

    // flatten the two sets into window order
    always_comb begin
        for (int i = 0; i < WP; i++) begin
            parcel_vec[i] = window_parcels[i / PPS][16*(i % PPS) +: 16];
        end
    end

    // ------------------------------------------------------------
    // per-way pick, oldest marker first

    always_comb begin
        istream_pkg::window_mask_t  remaining;
        istream_pkg::window_index_t lower_idx;
        istream_pkg::window_index_t upper_idx;
        logic                       lower_found;
        logic                       upper_found;
        logic                       blocked;

        remaining        = window_marker;
        blocked          = 1'b0;
        ack_vec          = '0;
        valid_by_way_deq = '0;
        for (int w = 0; w < istream_pkg::DEQ_WAYS; w++) begin
            lower_found = 1'b0;
            lower_idx   = '0;
            for (int i = WP - 1; i >= 0; i--) begin
                if (remaining[i]) begin
                    lower_found = 1'b1;
                    lower_idx   = istream_pkg::window_index_t'(i);
                end
            end

            // upper half is the next valid parcel after the lower
            upper_found = 1'b0;
            upper_idx   = '0;
            for (int i = WP - 1; i >= 0; i--) begin
                if (window_valid[i] && (i > int'(lower_idx))) begin
                    upper_found = 1'b1;
                    upper_idx   = istream_pkg::window_index_t'(i);
                end
            end

            instr_by_way_deq[w] = '0;
            pc_by_way_deq[w]    = {window_pc[lower_idx[3]], lower_idx[2:0], 1'b0};

            // a missing instr stalls this way and all after it
            if (!lower_found || (window_uncompressed[lower_idx] && !upper_found)) begin
                blocked = 1'b1;
            end

            if (!blocked) begin
                valid_by_way_deq[w]       = 1'b1;
                ack_vec[lower_idx]        = 1'b1;
                remaining[lower_idx]      = 1'b0;
                instr_by_way_deq[w][15:0] = parcel_vec[lower_idx];
                if (window_uncompressed[lower_idx]) begin
                    ack_vec[upper_idx]         = 1'b1;
                    instr_by_way_deq[w][31:16] = parcel_vec[upper_idx];
                end
            end
        end
    end

    assign valid_deq = valid_by_way_deq[0];

    // ------------------------------------------------------------
    // set retirement

    // done when nothing valid is left unacked
    assign set0_done = set_present[0] & ~|(window_valid[0 +: PPS] & ~ack_vec[0 +: PPS]);
    assign set1_done = set_present[1] & ~|(window_valid[PPS +: PPS] & ~ack_vec[PPS +: PPS]);

    assign retire_one = set0_done;
    assign retire_two = set0_done & set1_done;

    // ways fill from way 0 upward with no gaps
    always_comb begin
        assert (((valid_by_way_deq >> 1) & ~valid_by_way_deq) == '0)
            else $error("way valid out of order %b", valid_by_way_deq);
    end

endmodule

// File: include/tb_istream_table.svh
    // one fetch block per row, applied in order
    // columns: parcel_valid_enq, parcels 7..0, block_pc_enq, hold stall_deq, restart first

    localparam int NUM_ROWS = 21;

    localparam row_t ROWS [NUM_ROWS] = '{
        // eight 16-bit parcels
        '{8'hff, 128'ha71c_a618_a514_a410_a30c_a208_a104_a000, 28'h0001000, 1'b0, 1'b0},
        // 32-bit instr split across these two blocks
        '{8'hff, 128'hb7a3_b600_b500_b401_b302_b2ff_b103_b000, 28'h0001001, 1'b0, 1'b0},
        '{8'hff, 128'hc700_c602_c501_c400_c3aa_c203_c100_c0ff, 28'h0001002, 1'b0, 1'b0},
        // holes, some between the halves of a 32-bit instr
        '{8'had, 128'hd7ee_ffff_d503_ffff_d3ee_d203_ffff_d000, 28'h0002000, 1'b0, 1'b0},
        '{8'h00, 128'hffff_ffff_ffff_ffff_ffff_ffff_ffff_ffff, 28'h0002001, 1'b0, 1'b0},
        '{8'h3c, 128'hffff_ffff_e503_e400_e3ee_e203_ffff_ffff, 28'h0002002, 1'b0, 1'b0},
        '{8'he1, 128'hf702_f601_f500_ffff_ffff_ffff_ffff_f0ee, 28'h0002003, 1'b0, 1'b0},
        // dequeue held, more blocks than sets
        '{8'hff, 128'h1700_1601_1502_1400_1300_1201_1102_1000, 28'h0003000, 1'b1, 1'b0},
        '{8'hff, 128'h2703_2600_25ee_2403_2300_2201_2102_2000, 28'h0003001, 1'b1, 1'b0},
        '{8'hff, 128'h3702_3601_35cc_3403_3300_3201_3100_30bb, 28'h0003002, 1'b1, 1'b0},
        '{8'hff, 128'h4700_4600_4500_4400_4300_4200_4100_4000, 28'h0003003, 1'b1, 1'b0},
        '{8'hff, 128'h5703_56ee_5503_54ee_5303_52ee_5103_50ee, 28'h0003004, 1'b1, 1'b0},
        '{8'hff, 128'h6700_6600_6500_6400_6300_6200_6100_60dd, 28'h0003005, 1'b1, 1'b0},
        '{8'hff, 128'h7700_7600_7500_7400_7300_7200_7100_7000, 28'h0003006, 1'b1, 1'b0},
        '{8'hff, 128'h8700_8600_8500_8400_8300_8200_8100_8000, 28'h0003007, 1'b1, 1'b0},
        '{8'hff, 128'h0703_0600_0500_0400_0300_0200_0100_0000, 28'h0003008, 1'b1, 1'b0},
        '{8'hff, 128'h0f00_0e00_0d00_0c00_0b00_0a00_0900_08ee, 28'h0003009, 1'b1, 1'b0},
        // lower half left pending, then restart
        '{8'hff, 128'h2f03_2e00_2d00_2c00_2b00_2a00_2900_2800, 28'h0003100, 1'b0, 1'b0},
        '{8'hff, 128'h9702_9601_9500_9400_9300_9200_9100_9002, 28'h0004000, 1'b0, 1'b1},
        '{8'hff, 128'h5fee_5e03_5d00_5c01_5bee_5a03_5901_5800, 28'h0004001, 1'b0, 1'b0},
        '{8'h7e, 128'h6f00_6e01_6d02_6c00_6b01_6a02_6900_6800, 28'h0004002, 1'b0, 1'b0}
    };

// File: tests/tb_istream.sv
`timescale 1ns/1ps

module tb_istream;

    localparam int TIMEOUT = 400;

    typedef struct packed {
        logic [7:0]   mask;
        logic [127:0] parcels;
        logic [27:0]  pc;
        logic         hold;
        logic         restart;
    } row_t;

    `include "tb_istream_table.svh"

    logic             CLK;
    logic             nRST;
    logic             valid_enq;
    logic [7:0]       parcel_valid_enq;
    logic [127:0]     parcels_enq;
    logic [27:0]      block_pc_enq;
    logic             stall_enq;
    logic             valid_deq;
    logic [3:0]       valid_by_way_deq;
    logic [3:0][31:0] instr_by_way_deq;
    logic [3:0][31:0] pc_by_way_deq;
    logic             stall_deq;
    logic             restart;

    // reference model
    logic [31:0]      exp_instr [$];
    logic [31:0]      exp_pc [$];
    logic             pending;
    logic [15:0]      pending_parcel;
    logic [31:0]      pending_pc;

    // previous sample, for the stall hold check
    logic             prev_stall;
    logic             prev_restart;
    logic [3:0]       prev_valid;
    logic [3:0][31:0] prev_instr;
    logic [3:0][31:0] prev_pc;

    integer           seed;
    logic [31:0]      rnd;
    logic [31:0]      want_instr;
    logic [31:0]      want_pc;
    logic             hold_stall;
    logic             hold_now;
    logic             saw_full;
    logic             timed_out;
    int               errors;
    int               checked;

    istream u_istream (.*);

    initial CLK = 1'b0;
    always #2 CLK = ~CLK;

    // dequeue back-pressure, random unless held
    always @(posedge CLK) begin
        hold_now = hold_stall;
        #1;
        rnd = $random(seed);
        stall_deq = hold_now | rnd[0];
    end

    // ------------------------------------------------------------
    // model

    task automatic clear_model();
        exp_instr.delete();
        exp_pc.delete();
        pending = 1'b0;
    endtask

    // walk valid parcels, pairing 32-bit halves
    task automatic accept_block(input row_t row);
        logic [15:0] p;
        logic [31:0] parcel_pc;
        for (int i = 0; i < 8; i++) begin
            p         = row.parcels[16*i +: 16];
            parcel_pc = {row.pc, i[2:0], 1'b0};
            if (row.mask[i]) begin
                if (pending) begin
                    exp_instr.push_back({p, pending_parcel});
                    exp_pc.push_back(pending_pc);
                    pending = 1'b0;
                end else if (p[1:0] == 2'b11) begin
                    pending        = 1'b1;
                    pending_parcel = p;
                    pending_pc     = parcel_pc;
                end else begin
                    exp_instr.push_back({16'h0000, p});
                    exp_pc.push_back(parcel_pc);
                end
            end
        end
    endtask

    // called and returns 1 ns after a rising edge
    task automatic send_block(input row_t row);
        int wait_cycles;
        if (row.restart) begin
            restart = 1'b1;
            @(posedge CLK);
            clear_model();
            #1;
            restart = 1'b0;
        end
        hold_stall       = row.hold;
        valid_enq        = 1'b1;
        parcel_valid_enq = row.mask;
        parcels_enq      = row.parcels;
        block_pc_enq     = row.pc;
        wait_cycles      = 0;
        @(negedge CLK);
        while (stall_enq && wait_cycles < TIMEOUT) begin
            // queue filled up, let it drain
            if (hold_stall) begin
                saw_full   = 1'b1;
                hold_stall = 1'b0;
            end
            @(negedge CLK);
            wait_cycles++;
        end
        if (!stall_enq) begin
            @(posedge CLK);
            accept_block(row);
        end else begin
            $display("timeout: stall_enq stayed high for %0d cycles at %0t", TIMEOUT, $time);
            errors++;
            timed_out = 1'b1;
        end
        #1;
        valid_enq = 1'b0;
    endtask

    // called and returns 1 ns after a rising edge
    task automatic wait_drained();
        int wait_cycles;
        wait_cycles = 0;
        while (exp_instr.size() != 0 && wait_cycles < TIMEOUT) begin
            @(posedge CLK);
            wait_cycles++;
        end
        #1;
        assert (exp_instr.size() == 0) else begin
            $display("timeout: %0d expected instructions never came out", exp_instr.size());
            errors++;
            timed_out = 1'b1;
        end
    endtask

    // ------------------------------------------------------------
    // output checks, sampled mid-cycle

    always @(negedge CLK) begin
        if (nRST) begin
            for (int w = 0; w < 4; w++) begin
                if (prev_stall && !prev_restart && prev_valid[w]) begin
                    assert (valid_by_way_deq[w]) else begin
                        $display("Fail at %0t: valid_by_way_deq[%0d] is 0, expected 1", $time, w);
                        errors++;
                    end
                    assert (instr_by_way_deq[w] == prev_instr[w]) else begin
                        $display("Fail at %0t: instr_by_way_deq[%0d] is %h, expected %h",
                                 $time, w, instr_by_way_deq[w], prev_instr[w]);
                        errors++;
                    end
                    assert (pc_by_way_deq[w] == prev_pc[w]) else begin
                        $display("Fail at %0t: pc_by_way_deq[%0d] is %h, expected %h",
                                 $time, w, pc_by_way_deq[w], prev_pc[w]);
                        errors++;
                    end
                end
                if (valid_deq && !stall_deq && !restart && valid_by_way_deq[w]) begin
                    assert (exp_instr.size() != 0) begin
                        want_instr = exp_instr.pop_front();
                        want_pc    = exp_pc.pop_front();
                        checked++;
                        assert (instr_by_way_deq[w] == want_instr) else begin
                            $display("Fail at %0t: instr_by_way_deq[%0d] is %h, expected %h",
                                     $time, w, instr_by_way_deq[w], want_instr);
                            errors++;
                        end
                        assert (pc_by_way_deq[w] == want_pc) else begin
                            $display("Fail at %0t: pc_by_way_deq[%0d] is %h, expected %h",
                                     $time, w, pc_by_way_deq[w], want_pc);
                            errors++;
                        end
                    end else begin
                        $display("way %0d gave an instruction nobody expects at %0t", w, $time);
                        errors++;
                    end
                end
            end
            prev_stall   = stall_deq;
            prev_restart = restart;
            prev_valid   = valid_by_way_deq;
            prev_instr   = instr_by_way_deq;
            prev_pc      = pc_by_way_deq;
        end
    end

    // ------------------------------------------------------------
    // main sequence

    initial begin
        seed             = 32'h4cd;
        nRST             = 1'b0;
        valid_enq        = 1'b0;
        parcel_valid_enq = '0;
        parcels_enq      = '0;
        block_pc_enq     = '0;
        stall_deq        = 1'b0;
        restart          = 1'b0;
        hold_stall       = 1'b0;
        saw_full         = 1'b0;
        timed_out        = 1'b0;
        errors           = 0;
        checked          = 0;
        pending          = 1'b0;
        pending_parcel   = '0;
        pending_pc       = '0;
        prev_stall       = 1'b0;
        prev_restart     = 1'b0;
        prev_valid       = '0;
        prev_instr       = '0;
        prev_pc          = '0;
        repeat (4) @(posedge CLK);
        #1;
        nRST = 1'b1;

        // empty after reset
        @(negedge CLK);
        assert (!valid_deq) else begin
            $display("Fail at %0t: valid_deq is %b, expected 0", $time, valid_deq);
            errors++;
        end
        assert (!stall_enq) else begin
            $display("Fail at %0t: stall_enq is %b, expected 0", $time, stall_enq);
            errors++;
        end
        assert (valid_by_way_deq == 4'b0000) else begin
            $display("Fail at %0t: valid_by_way_deq is %b, expected 0000",
                     $time, valid_by_way_deq);
            errors++;
        end

        @(posedge CLK);
        #1;
        for (int r = 0; r < NUM_ROWS && !timed_out; r++) begin
            if (r > 0 && ROWS[r-1].hold && !ROWS[r].hold) begin
                // release the held dequeue and let the backlog out
                hold_stall = 1'b0;
                wait_drained();
            end
            send_block(ROWS[r]);
        end
        hold_stall = 1'b0;

        wait_drained();
        assert (saw_full) else begin
            $display("stall_enq never rose while dequeue was held");
            errors++;
        end

        $display("errors: %0d, instructions checked: %0d", errors, checked);
        if (errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule
